// File: source/bp_pkg.sv
// sizes are fixed localparams; INSTR_PER_FETCH, NR_ROWS and FIFO_DEPTH must be powers of two
`default_nettype none

package bp_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------

  // virtual address width
  localparam int unsigned VLEN = 32;
  // instruction slots looked up per fetch block
  localparam int unsigned INSTR_PER_FETCH = 2;
  // total number of 2-bit counters
  localparam int unsigned NR_ENTRIES = 64;
  // table reshaped into rows of one fetch block each
  localparam int unsigned NR_ROWS = NR_ENTRIES / INSTR_PER_FETCH;
  // compressed instructions allowed, so only bit 0 is always zero
  localparam int unsigned OFFSET = 1;
  // slot inside a row
  localparam int unsigned ROW_ADDR_BITS = $clog2(INSTR_PER_FETCH);
  // row select
  localparam int unsigned ROW_BITS = $clog2(NR_ROWS);
  // pending update records
  localparam int unsigned FIFO_DEPTH = 4;
  // queue pointer and fill count widths
  localparam int unsigned FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

  // ----------------------------------------------------------
  // records
  // ----------------------------------------------------------

  // per-slot prediction toward the front end
  typedef struct packed {
    logic valid;
    logic taken;
  } bht_prediction_t;

  // resolved branch; validity travels as a separate strobe
  typedef struct packed {
    logic [VLEN-1:0] pc;
    logic            taken;
  } bht_update_t;

endpackage

`default_nettype wire

// File: source/branch_resolver.sv
// one registered record per resolve; debug-mode resolves are dropped silently, no back-pressure
`default_nettype none

module branch_resolver (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    debug_mode_i,
  input  wire logic                    resolve_valid_i,
  input  wire logic [bp_pkg::VLEN-1:0] resolve_pc_i,
  input  wire logic                    resolve_taken_i,
  input  wire logic                    resolve_pred_taken_i,
  output logic                         upd_push_o,
  output bp_pkg::bht_update_t          upd_rec_o,
  output logic                         mispredict_o
);
  import bp_pkg::*;

  // a resolve counts only outside debug mode
  logic        qualify;
  logic        push_q;
  logic        mispredict_q;
  bht_update_t rec_q;

  assign qualify = resolve_valid_i && !debug_mode_i;

  // control strobes, one cycle after the resolve
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q       <= 1'b0;
      mispredict_q <= 1'b0;
    end else begin
      push_q       <= qualify;
      // direction actually taken differs from the fetched prediction
      mispredict_q <= qualify && (resolve_taken_i != resolve_pred_taken_i);
    end
  end

  // record payload, loaded with every qualifying resolve
  always_ff @(posedge clk_i) begin
    if (qualify) begin
      rec_q.pc    <= resolve_pc_i;
      rec_q.taken <= resolve_taken_i;
    end
  end

  assign upd_push_o   = push_q;
  assign upd_rec_o    = rec_q;
  assign mispredict_o = mispredict_q;

  // both outputs trace back to a qualifying resolve one cycle earlier
  a_push_has_source: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (upd_push_o || mispredict_o) |-> $past(resolve_valid_i && !debug_mode_i)
  );

endmodule

`default_nettype wire

// File: source/resolve_fifo.sv
// caller must not pop while empty; FIFO_DEPTH must be a power of two; a full push without pop is lost
`default_nettype none

module resolve_fifo #(
  parameter type entry_t = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic flush_i,
  input  wire logic push_i,
  input  entry_t    data_i,
  input  wire logic pop_i,
  output logic      empty_o,
  output entry_t    head_o,
  output logic      dropped_o
);
  import bp_pkg::*;

  entry_t                   mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_BITS-1:0] wr_ptr_q;
  logic [FIFO_PTR_BITS-1:0] rd_ptr_q;
  logic [FIFO_CNT_BITS-1:0] count_q;
  logic                     full;
  logic                     do_push;
  logic                     do_pop;

  // ----------------------------------------------------------
  // status and accepted operations
  // ----------------------------------------------------------

  assign full    = (count_q == FIFO_CNT_BITS'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  // a pop in the same cycle frees the slot for the push
  assign do_push = push_i && (!full || pop_i) && !flush_i;
  assign do_pop  = pop_i && !flush_i;
  // a lost push pulses in its own cycle and a flushed push is no drop
  assign dropped_o = push_i && full && !pop_i && !flush_i;

  assign head_o = mem_q[rd_ptr_q];

  // ----------------------------------------------------------
  // pointers and count
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers roll over past the last entry of the storage
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count unchanged
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage is written at the end of the push cycle
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the consumer checks for data before it pops
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o
  );

  a_count_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) count_q <= FIFO_CNT_BITS'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// File: source/bht.sv
// flop table, no aliasing tags; one update per two cycles, lookup is combinational from vpc_i
`default_nettype none

module bht (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    flush_bp_i,
  input  wire logic [bp_pkg::VLEN-1:0] vpc_i,
  input  wire logic                    queue_empty_i,
  input  bp_pkg::bht_update_t          update_i,
  output logic                         queue_pop_o,
  output bp_pkg::bht_prediction_t [bp_pkg::INSTR_PER_FETCH-1:0] bht_prediction_o
);
  import bp_pkg::*;

  // one table entry
  typedef struct packed {
    logic       valid;
    logic [1:0] counter;
  } bht_entry_t;

  // bit position of the row field inside a pc
  localparam int unsigned ROW_LSB = ROW_ADDR_BITS + OFFSET;

  bht_entry_t               tbl_q [NR_ROWS][INSTR_PER_FETCH];
  logic [ROW_BITS-1:0]      lookup_row;
  logic [ROW_BITS-1:0]      upd_row;
  logic [ROW_ADDR_BITS-1:0] upd_slot;
  logic [1:0]               cur_cnt;
  logic [1:0]               nxt_cnt;
  logic                     busy_q;
  bht_update_t              stage_q;

  // ----------------------------------------------------------
  // lookup
  // ----------------------------------------------------------

  // row of the fetch block; the slot bits pick the output lane
  assign lookup_row = vpc_i[ROW_LSB+ROW_BITS-1:ROW_LSB];

  for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_pred
    assign bht_prediction_o[i].valid = tbl_q[lookup_row][i].valid;
    // upper half of the counter range predicts taken
    assign bht_prediction_o[i].taken = tbl_q[lookup_row][i].counter[1];
  end

  // ----------------------------------------------------------
  // update stage
  // ----------------------------------------------------------

  // take one record when idle; a flush cycle takes nothing
  assign queue_pop_o = !queue_empty_i && !busy_q && !flush_bp_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      // queue_pop_o is already low during a flush, which cancels the stage
      busy_q <= queue_pop_o;
    end
  end

  // record latched in the pop cycle
  always_ff @(posedge clk_i) begin
    if (queue_pop_o) begin
      stage_q <= update_i;
    end
  end

  assign upd_row  = stage_q.pc[ROW_LSB+ROW_BITS-1:ROW_LSB];
  assign upd_slot = stage_q.pc[ROW_LSB-1:OFFSET];

  // saturating step toward the resolved direction
  always_comb begin
    cur_cnt = tbl_q[upd_row][upd_slot].counter;
    if (stage_q.taken) begin
      nxt_cnt = (cur_cnt == 2'b11) ? cur_cnt : cur_cnt + 2'd1;
    end else begin
      nxt_cnt = (cur_cnt == 2'b00) ? cur_cnt : cur_cnt - 2'd1;
    end
  end

  // ----------------------------------------------------------
  // table storage
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          tbl_q[r][s] <= '0;
        end
      end
    end else if (flush_bp_i) begin
      // evict everything, counters restart weakly taken
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          tbl_q[r][s].valid   <= 1'b0;
          tbl_q[r][s].counter <= 2'b10;
        end
      end
    end else if (busy_q) begin
      // write back at the end of the busy cycle
      tbl_q[upd_row][upd_slot].valid   <= 1'b1;
      tbl_q[upd_row][upd_slot].counter <= nxt_cnt;
    end
  end

  // the two-cycle read-modify-write forbids back-to-back pops
  a_pop_spacing: assert property (
    @(posedge clk_i) disable iff (!rst_ni) queue_pop_o |=> !queue_pop_o
  );

endmodule

`default_nettype wire

// File: source/bp_top.sv
// resolve to prediction takes four cycles when idle; more than FIFO_DEPTH waiting records are dropped
`default_nettype none

module bp_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    flush_bp_i,
  input  wire logic                    debug_mode_i,
  input  wire logic [bp_pkg::VLEN-1:0] vpc_i,
  input  wire logic                    resolve_valid_i,
  input  wire logic [bp_pkg::VLEN-1:0] resolve_pc_i,
  input  wire logic                    resolve_taken_i,
  input  wire logic                    resolve_pred_taken_i,
  output bp_pkg::bht_prediction_t [bp_pkg::INSTR_PER_FETCH-1:0] bht_prediction_o,
  output logic                         mispredict_o,
  output logic                         dropped_o
);
  import bp_pkg::*;

  // resolver to queue
  logic        upd_push;
  bht_update_t upd_rec;
  // queue to table
  logic        queue_empty;
  logic        queue_pop;
  bht_update_t head;

  // filters resolves and builds records
  branch_resolver u_resolver (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .debug_mode_i         (debug_mode_i),
    .resolve_valid_i      (resolve_valid_i),
    .resolve_pc_i         (resolve_pc_i),
    .resolve_taken_i      (resolve_taken_i),
    .resolve_pred_taken_i (resolve_pred_taken_i),
    .upd_push_o           (upd_push),
    .upd_rec_o            (upd_rec),
    .mispredict_o         (mispredict_o)
  );

  // absorbs resolve bursts while the table is busy
  resolve_fifo #(
    .entry_t (bht_update_t)
  ) u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_bp_i),
    .push_i    (upd_push),
    .data_i    (upd_rec),
    .pop_i     (queue_pop),
    .empty_o   (queue_empty),
    .head_o    (head),
    .dropped_o (dropped_o)
  );

  // counters and lookup
  bht u_bht (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_bp_i       (flush_bp_i),
    .vpc_i            (vpc_i),
    .queue_empty_i    (queue_empty),
    .update_i         (head),
    .queue_pop_o      (queue_pop),
    .bht_prediction_o (bht_prediction_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_bp_top.sv
// cycle model of resolver, queue and table checked every cycle; pc pool aliases rows on purpose
`default_nettype none

module tb_bp_top;
  timeunit 1ns;
  timeprecision 1ps;
  import bp_pkg::*;

  localparam int SAT_RUNS = 80;
  localparam int DBG_N    = 40;
  localparam int MISP_N   = 200;
  localparam int BURST_N  = 10;
  // worst-case cycles per test, summed for the watchdog
  localparam int TEST_CYCLES = NR_ROWS + SAT_RUNS * 4 * 5 + (DBG_N + 4) + 90
                               + (MISP_N + 5) + (BURST_N + 12 + NR_ROWS);
  localparam int TIMEOUT  = 2 * TEST_CYCLES;
  localparam int IDX_BITS = ROW_BITS + ROW_ADDR_BITS;
  // rows 0, 2, 3, 5 and 31, both slots
  localparam logic [VLEN-1:0] POOL [8] = '{32'h0000_1000, 32'h0000_1002, 32'h0000_1014,
    32'h0000_1016, 32'h0000_107c, 32'h0000_107e, 32'h0000_1008, 32'h0000_100e};

  logic clk, rst_n, flush, dbg, res_valid, res_taken, res_pred, misp, dropped;
  logic [VLEN-1:0] vpc, res_pc;
  bht_prediction_t [INSTR_PER_FETCH-1:0] pred;

  // reference state
  logic        m_valid [NR_ENTRIES];
  logic [1:0]  m_cnt   [NR_ENTRIES];
  bht_update_t m_queue [$];
  bht_update_t m_rec, m_stage;
  logic        m_push, m_misp, m_busy;
  logic [31:0] lfsr_q;
  int          cycles, errors, errors_at_start, tests_ok, tests_bad;

  bp_top u_bp_top (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .flush_bp_i           (flush),
    .debug_mode_i         (dbg),
    .vpc_i                (vpc),
    .resolve_valid_i      (res_valid),
    .resolve_pc_i         (res_pc),
    .resolve_taken_i      (res_taken),
    .resolve_pred_taken_i (res_pred),
    .bht_prediction_o     (pred),
    .mispredict_o         (misp),
    .dropped_o            (dropped)
  );

  // ----------------------------------------------------------
  // random source and helpers
  // ----------------------------------------------------------

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic take_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic logic [2:0] take_idx();
    logic [2:0] v;
    for (int i = 0; i < 3; i++) begin
      v[i] = take_bit();
    end
    return v;
  endfunction

  // flat counter index, slot bits above OFFSET and row bits above those
  function automatic int entry_of(input logic [VLEN-1:0] pc);
    return int'(pc[OFFSET +: IDX_BITS]);
  endfunction

  task automatic check_prediction(input bp_pkg::bht_prediction_t got,
                                  input bp_pkg::bht_prediction_t want, input string what);
    if (got !== want) begin
      errors++;
      $display("Fail at %0t: %s predicted valid %b taken %b, expected valid %b taken %b",
               $time, what, got.valid, got.taken, want.valid, want.taken);
    end
  endtask

  task automatic check_pulse(input logic got, input logic want, input string what);
    if (got !== want) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------

  task automatic model_reset();
    for (int i = 0; i < NR_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
      m_cnt[i]   = 2'd0;
    end
    m_queue.delete();
    m_push = 1'b0;
    m_misp = 1'b0;
    m_busy = 1'b0;
  endtask

  task automatic check_outputs();
    bht_prediction_t want;
    logic            pop;
    int              e;
    pop = (m_queue.size() != 0) && !m_busy && !flush;
    check_pulse(misp, m_misp, "mispredict_o");
    check_pulse(dropped, m_push && (m_queue.size() == FIFO_DEPTH) && !pop && !flush,
                "dropped_o");
    for (int i = 0; i < INSTR_PER_FETCH; i++) begin
      e = entry_of(vpc) / INSTR_PER_FETCH * INSTR_PER_FETCH + i;
      want.valid = m_valid[e];
      want.taken = m_cnt[e][1];
      check_prediction(pred[i], want, $sformatf("pc %h slot %0d", vpc, i));
    end
  endtask

  // state at the coming clock edge, from this cycle's inputs
  task automatic model_advance();
    logic pop;
    int   e;
    pop = (m_queue.size() != 0) && !m_busy && !flush;
    if (flush) begin
      for (int i = 0; i < NR_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
        m_cnt[i]   = 2'd2;
      end
    end else if (m_busy) begin
      e = entry_of(m_stage.pc);
      m_valid[e] = 1'b1;
      if (m_stage.taken && m_cnt[e] != 2'd3) begin
        m_cnt[e] = m_cnt[e] + 2'd1;
      end else if (!m_stage.taken && m_cnt[e] != 2'd0) begin
        m_cnt[e] = m_cnt[e] - 2'd1;
      end
    end
    m_busy = pop;
    if (flush) begin
      m_queue.delete();
    end else begin
      if (pop) begin
        m_stage = m_queue.pop_front();
      end
      // a same-cycle pop makes room
      if (m_push && m_queue.size() < FIFO_DEPTH) begin
        m_queue.push_back(m_rec);
      end
    end
    m_push = res_valid && !dbg;
    m_misp = m_push && (res_taken != res_pred);
    if (m_push) begin
      m_rec.pc    = res_pc;
      m_rec.taken = res_taken;
    end
  endtask

  // ----------------------------------------------------------
  // cycle driving
  // ----------------------------------------------------------

  // called 1 ns after an edge; checks at the falling edge
  task automatic tick();
    #4;
    check_outputs();
    model_advance();
    @(posedge clk);
    #1;
  endtask

  task automatic resolve(input logic [VLEN-1:0] pc, input logic taken, input logic predicted,
                         input logic debug);
    res_valid = 1'b1;
    res_pc    = pc;
    res_taken = taken;
    res_pred  = predicted;
    dbg       = debug;
    tick();
    res_valid = 1'b0;
    dbg       = 1'b0;
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      tick();
    end
  endtask

  task automatic sweep_rows();
    for (int r = 0; r < NR_ROWS; r++) begin
      vpc = VLEN'(r) << (OFFSET + ROW_ADDR_BITS);
      tick();
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      tests_ok++;
      $display("test %s finished cleanly", name);
    end else begin
      tests_bad++;
      $display("test %s finished with %0d errors", name, errors - errors_at_start);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #5;
      clk = ~clk;
    end
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the tests did not finish within %0d cycles", TIMEOUT);
    $display("Regression failed");
    $finish;
  end

  initial begin
    logic [2:0]      k;
    logic            dir;
    int              len;
    bht_prediction_t want;
    lfsr_q    = 32'h9c20_61aa;
    errors    = 0;
    tests_ok  = 0;
    tests_bad = 0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    dbg       = 1'b0;
    res_valid = 1'b0;
    res_taken = 1'b0;
    res_pred  = 1'b0;
    res_pc    = '0;
    vpc       = '0;
    model_reset();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test();
    sweep_rows();
    finish_test("reset");

    // runs of up to four equal outcomes on one pc
    start_test();
    for (int r = 0; r < SAT_RUNS; r++) begin
      k   = take_idx();
      dir = take_bit();
      len = {take_bit(), take_bit()} + 1;
      vpc = POOL[k];
      for (int n = 0; n < len; n++) begin
        resolve(POOL[k], dir, take_bit(), 1'b0);
        idle(4);
      end
    end
    finish_test("saturation");

    start_test();
    for (int n = 0; n < DBG_N; n++) begin
      k   = take_idx();
      vpc = POOL[k];
      resolve(POOL[k], take_bit(), take_bit(), 1'b1);
    end
    idle(4);
    finish_test("debug mode");

    // train, leave records pending, then flush
    start_test();
    for (int n = 0; n < 8; n++) begin
      resolve(POOL[take_idx()], take_bit(), take_bit(), 1'b0);
      idle(4);
    end
    for (int n = 0; n < 3; n++) begin
      resolve(POOL[n], 1'b1, 1'b1, 1'b0);
    end
    flush = 1'b1;
    tick();
    flush = 1'b0;
    sweep_rows();
    // counters restart at 2, one step either way
    vpc = POOL[2];
    resolve(POOL[2], 1'b1, 1'b1, 1'b0);
    idle(4);
    want.valid = 1'b1;
    want.taken = 1'b1;
    check_prediction(pred[POOL[2][OFFSET +: ROW_ADDR_BITS]], want, "taken after flush");
    vpc = POOL[3];
    resolve(POOL[3], 1'b0, 1'b0, 1'b0);
    idle(4);
    want.taken = 1'b0;
    check_prediction(pred[POOL[3][OFFSET +: ROW_ADDR_BITS]], want, "not taken after flush");
    finish_test("flush");

    start_test();
    for (int n = 0; n < MISP_N; n++) begin
      k         = take_idx();
      vpc       = POOL[k];
      res_pc    = POOL[k];
      res_valid = take_bit();
      res_taken = take_bit();
      res_pred  = take_bit();
      dbg       = take_bit() & take_bit();
      tick();
    end
    res_valid = 1'b0;
    dbg       = 1'b0;
    idle(5);
    finish_test("mispredict");

    // pushes outrun the two-cycle drain
    start_test();
    for (int n = 0; n < BURST_N; n++) begin
      resolve(POOL[take_idx()], take_bit(), take_bit(), 1'b0);
    end
    for (int n = 0; n < 12; n++) begin
      vpc = POOL[n % 8];
      tick();
    end
    sweep_rows();
    finish_test("burst and drop");

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (tests_bad == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
source/bp_pkg.sv
source/branch_resolver.sv
source/resolve_fifo.sv
source/bht.sv
source/bp_top.sv
testbench/tb_bp_top.sv

// File: run.sh
#!/bin/sh
# compile and run the predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_bp_top -Mdir obj_dir -o tb_bp_top -f project.f

status=0
./obj_dir/tb_bp_top > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  exit "$status"
fi

# the log decides the verdict
if grep -q "Regression passed" sim.log; then
  exit 0
fi
exit 1
